// File: hdl/eeprom_defs.svh
`ifndef EEPROM_DEFS_SVH
`define EEPROM_DEFS_SVH

// 2 KB part with the high three address bits in the control byte
`define EE_ADDR_W 11
`define EE_DATA_W 8

`define EE_SCL_HALF 4 // system clocks per scl half period (3 or more)

`define EE_DEV_TYPE 4'b1010

`endif

// File: hdl/eeprom_pkg.sv
`default_nettype none

`include "eeprom_defs.svh"

package eeprom_pkg;

    // bit engine operations
    typedef enum logic [1:0] {
        PHY_START,
        PHY_STOP,
        PHY_WRITE,
        PHY_READ
    } phy_cmd_e;

    // control byte, shifted raw by the phy and built by fields in the sequencer
    typedef union packed {
        logic [`EE_DATA_W-1:0] raw;
        struct packed {
            logic [3:0]                      dev_type;
            logic [`EE_ADDR_W-`EE_DATA_W-1:0] block;
            logic                            rnw;
        } f;
    } ctrl_byte_u;

endpackage

`default_nettype wire

// File: hdl/eeprom_req_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defs.svh"

interface eeprom_req_if;
    logic                  wr;
    logic                  rd;
    logic [`EE_ADDR_W-1:0] addr;
    logic [`EE_DATA_W-1:0] wdata;
    logic                  ack;   // one cycle, ends the request
    logic [`EE_DATA_W-1:0] rdata;
    logic                  err;

    modport arb (output wr, rd, addr, wdata, input ack, rdata, err);

    modport seq (input wr, rd, addr, wdata, output ack, rdata, err);

endinterface

`default_nettype wire

// File: hdl/i2c_phy_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defs.svh"

interface i2c_phy_if;
    logic                    cmd_valid; // pulse, phy idle only
    eeprom_pkg::phy_cmd_e    cmd;
    eeprom_pkg::ctrl_byte_u  tx_byte;
    logic                    tx_nack;   // master ack bit after a read
    logic                    done;
    logic [`EE_DATA_W-1:0]   rx_byte;
    logic                    rx_ack;    // 1 = slave acked

    modport seq (output cmd_valid, cmd, tx_byte, tx_nack, input done, rx_byte, rx_ack);

    modport phy (input cmd_valid, cmd, tx_byte, tx_nack, output done, rx_byte, rx_ack);

endinterface

`default_nettype wire

// File: hdl/eeprom_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defs.svh"

module eeprom_arbiter (
    input  wire                   CLK,
    input  wire                   RESET,
    input  wire                   a_wr,
    input  wire                   a_rd,
    input  wire  [`EE_ADDR_W-1:0] a_addr,
    input  wire  [`EE_DATA_W-1:0] a_wdata,
    input  wire                   b_wr,
    input  wire                   b_rd,
    input  wire  [`EE_ADDR_W-1:0] b_addr,
    input  wire  [`EE_DATA_W-1:0] b_wdata,
    output logic                  a_ack,
    output logic [`EE_DATA_W-1:0] a_rdata,
    output logic                  a_err,
    output logic                  b_ack,
    output logic [`EE_DATA_W-1:0] b_rdata,
    output logic                  b_err,
    eeprom_req_if.arb             req
);

    logic busy;
    logic sel;   // 1 = port b granted
    logic last;  // port served last
    logic a_req;
    logic b_req;
    logic pick_b;

    assign a_req  = a_wr | a_rd;
    assign b_req  = b_wr | b_rd;
    assign pick_b = b_req && (!a_req || !last); // on a tie the other port wins

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy <= 1'b0;
            sel  <= 1'b0;
            last <= 1'b1; // a wins the first tie
        end else if (!busy) begin
            if (a_req || b_req) begin
                busy <= 1'b1;
                sel  <= pick_b;
            end
        end else if (req.ack) begin
            busy <= 1'b0;
            last <= sel;
        end
    end

    assign req.wr    = busy && (sel ? b_wr : a_wr);
    assign req.rd    = busy && (sel ? b_rd : a_rd);
    assign req.addr  = sel ? b_addr : a_addr;
    assign req.wdata = sel ? b_wdata : a_wdata;

    assign a_ack   = busy && !sel && req.ack;
    assign b_ack   = busy && sel && req.ack;
    assign a_rdata = a_ack ? req.rdata : '0;
    assign b_rdata = b_ack ? req.rdata : '0;
    assign a_err   = a_ack && req.err;
    assign b_err   = b_ack && req.err;

endmodule

`default_nettype wire

// File: hdl/eeprom_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defs.svh"

module eeprom_sequencer (
    input wire        CLK,
    input wire        RESET,
    eeprom_req_if.seq req,
    i2c_phy_if.seq    phy
);

    // one-hot state bits
    localparam int S_IDLE     = 0;
    localparam int S_WR_START = 1;
    localparam int S_CTRL_WR  = 2;
    localparam int S_ADDR_WR  = 3;
    localparam int S_DATA_WR  = 4;
    localparam int S_RD_START = 5;
    localparam int S_CTRL_RD  = 6;
    localparam int S_DATA_RD  = 7;
    localparam int S_STOP     = 8;
    localparam int S_ACK      = 9;

    logic [9:0]             state;
    eeprom_pkg::ctrl_byte_u ctrl;

    always_comb begin
        ctrl.f.dev_type = `EE_DEV_TYPE;
        ctrl.f.block    = req.addr[`EE_ADDR_W-1:`EE_DATA_W];
        ctrl.f.rnw      = state[S_RD_START]; // read control goes out after the repeated start
    end

    assign req.ack = state[S_ACK];

    // each state waits for done of its own command, then issues the next one
    always_ff @(posedge CLK) begin
        if (RESET) begin
            state         <= 10'b1 << S_IDLE;
            req.err       <= 1'b0;
            phy.cmd_valid <= 1'b0;
        end else begin
            phy.cmd_valid <= 1'b0;
            case (1'b1)
                state[S_IDLE]: begin
                    if (req.wr || req.rd) begin
                        req.err       <= 1'b0;
                        req.rdata     <= '0;
                        phy.cmd_valid <= 1'b1;
                        phy.cmd       <= eeprom_pkg::PHY_START;
                        phy.tx_nack   <= 1'b0;
                        state         <= 10'b1 << S_WR_START;
                    end
                end
                state[S_WR_START]: begin
                    if (phy.done) begin
                        phy.cmd_valid <= 1'b1;
                        phy.cmd       <= eeprom_pkg::PHY_WRITE;
                        phy.tx_byte   <= ctrl;
                        state         <= 10'b1 << S_CTRL_WR;
                    end
                end
                state[S_CTRL_WR]: begin
                    if (phy.done) begin
                        phy.cmd_valid <= 1'b1;
                        if (!phy.rx_ack) begin // no device, give up
                            req.err <= 1'b1;
                            phy.cmd <= eeprom_pkg::PHY_STOP;
                            state   <= 10'b1 << S_STOP;
                        end else begin
                            phy.cmd         <= eeprom_pkg::PHY_WRITE;
                            phy.tx_byte.raw <= req.addr[`EE_DATA_W-1:0];
                            state           <= 10'b1 << S_ADDR_WR;
                        end
                    end
                end
                state[S_ADDR_WR]: begin
                    if (phy.done) begin
                        phy.cmd_valid <= 1'b1;
                        if (req.rd) begin
                            phy.cmd <= eeprom_pkg::PHY_START; // repeated start
                            state   <= 10'b1 << S_RD_START;
                        end else begin
                            phy.cmd         <= eeprom_pkg::PHY_WRITE;
                            phy.tx_byte.raw <= req.wdata;
                            state           <= 10'b1 << S_DATA_WR;
                        end
                    end
                end
                state[S_DATA_WR]: begin
                    if (phy.done) begin
                        phy.cmd_valid <= 1'b1;
                        phy.cmd       <= eeprom_pkg::PHY_STOP;
                        state         <= 10'b1 << S_STOP;
                    end
                end
                state[S_RD_START]: begin
                    if (phy.done) begin
                        phy.cmd_valid <= 1'b1;
                        phy.cmd       <= eeprom_pkg::PHY_WRITE;
                        phy.tx_byte   <= ctrl;
                        state         <= 10'b1 << S_CTRL_RD;
                    end
                end
                state[S_CTRL_RD]: begin
                    if (phy.done) begin
                        phy.cmd_valid <= 1'b1;
                        phy.cmd       <= eeprom_pkg::PHY_READ;
                        phy.tx_nack   <= 1'b1; // single byte, nack ends it
                        state         <= 10'b1 << S_DATA_RD;
                    end
                end
                state[S_DATA_RD]: begin
                    if (phy.done) begin
                        req.rdata     <= phy.rx_byte;
                        phy.cmd_valid <= 1'b1;
                        phy.cmd       <= eeprom_pkg::PHY_STOP;
                        state         <= 10'b1 << S_STOP;
                    end
                end
                state[S_STOP]: begin
                    if (phy.done) begin
                        state <= 10'b1 << S_ACK;
                    end
                end
                default: begin
                    state <= 10'b1 << S_IDLE; // ack lasts one cycle
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/i2c_byte_phy.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defs.svh"

module i2c_byte_phy (
    input  wire     CLK,
    input  wire     RESET,
    input  wire     sda_in,
    output logic    scl,
    output logic    sda_oe,   // 1 pulls sda low
    i2c_phy_if.phy  phy
);

    localparam int HALF  = `EE_SCL_HALF;
    localparam int MID   = HALF / 2;
    localparam int CNT_W = (HALF > 2) ? $clog2(HALF) : 1;

    logic                  busy;
    eeprom_pkg::phy_cmd_e  op;
    logic                  nack;
    logic [CNT_W-1:0]      cnt;    // clocks within a half period
    logic [4:0]            phase;  // half period index
    logic [4:0]            last_phase;
    logic                  in_ack;
    logic [`EE_DATA_W-1:0] shreg;  // out on writes, in on reads

    // a byte is nine bits of low and high halves, start and stop are two halves
    assign last_phase = (op == eeprom_pkg::PHY_WRITE || op == eeprom_pkg::PHY_READ) ?
                        5'd17 : 5'd1;
    assign in_ack     = (phase[4:1] == 4'd8);
    assign phy.rx_byte = shreg;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            scl        <= 1'b1;
            sda_oe     <= 1'b0;
            busy       <= 1'b0;
            cnt        <= '0;
            phase      <= '0;
            phy.done   <= 1'b0;
            phy.rx_ack <= 1'b0;
        end else begin
            phy.done <= 1'b0;
            if (!busy) begin
                if (phy.cmd_valid) begin
                    busy  <= 1'b1;
                    op    <= phy.cmd;
                    nack  <= phy.tx_nack;
                    shreg <= phy.tx_byte.raw;
                    cnt   <= '0;
                    phase <= '0;
                    if (phy.cmd == eeprom_pkg::PHY_START) begin
                        scl <= 1'b1; // repeated start raises scl first
                    end
                end
            end else begin
                cnt <= cnt + 1'b1;
                // sda moves in mid half, away from scl edges
                if (cnt == CNT_W'(MID)) begin
                    case (op)
                        eeprom_pkg::PHY_START: begin
                            if (phase[0]) begin
                                sda_oe <= 1'b1; // sda falls with scl high
                            end
                        end
                        eeprom_pkg::PHY_STOP: begin
                            sda_oe <= ~phase[0]; // low first, then rises with scl high
                        end
                        default: begin
                            if (!phase[0]) begin
                                if (in_ack) begin
                                    sda_oe <= (op == eeprom_pkg::PHY_READ) && !nack;
                                end else begin
                                    sda_oe <= (op == eeprom_pkg::PHY_WRITE) && !shreg[7];
                                end
                            end else if (in_ack) begin
                                if (op == eeprom_pkg::PHY_WRITE) begin
                                    phy.rx_ack <= !sda_in;
                                end
                            end else begin
                                shreg <= {shreg[`EE_DATA_W-2:0], sda_in};
                            end
                        end
                    endcase
                end
                if (cnt == CNT_W'(HALF - 1)) begin
                    cnt <= '0;
                    case (op)
                        eeprom_pkg::PHY_START: scl <= (phase == 5'd0);
                        eeprom_pkg::PHY_STOP:  scl <= 1'b1;
                        default:               scl <= ~phase[0];
                    endcase
                    if (phase == last_phase) begin
                        busy     <= 1'b0;
                        phy.done <= 1'b1;
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/eeprom_subsys.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defs.svh"

module eeprom_subsys (
    input  wire                   CLK,
    input  wire                   RESET,
    input  wire                   a_wr,
    input  wire                   a_rd,
    input  wire  [`EE_ADDR_W-1:0] a_addr,
    input  wire  [`EE_DATA_W-1:0] a_wdata,
    input  wire                   b_wr,
    input  wire                   b_rd,
    input  wire  [`EE_ADDR_W-1:0] b_addr,
    input  wire  [`EE_DATA_W-1:0] b_wdata,
    input  wire                   sda_in,
    output logic                  a_ack,
    output logic [`EE_DATA_W-1:0] a_rdata,
    output logic                  a_err,
    output logic                  b_ack,
    output logic [`EE_DATA_W-1:0] b_rdata,
    output logic                  b_err,
    output logic                  scl,
    output logic                  sda_oe
);

    eeprom_req_if req_bus ();
    i2c_phy_if    phy_bus ();

    eeprom_arbiter u_arb (
        .CLK     (CLK),
        .RESET   (RESET),
        .a_wr    (a_wr),
        .a_rd    (a_rd),
        .a_addr  (a_addr),
        .a_wdata (a_wdata),
        .b_wr    (b_wr),
        .b_rd    (b_rd),
        .b_addr  (b_addr),
        .b_wdata (b_wdata),
        .a_ack   (a_ack),
        .a_rdata (a_rdata),
        .a_err   (a_err),
        .b_ack   (b_ack),
        .b_rdata (b_rdata),
        .b_err   (b_err),
        .req     (req_bus)
    );

    eeprom_sequencer u_seq (
        .CLK   (CLK),
        .RESET (RESET),
        .req   (req_bus),
        .phy   (phy_bus)
    );

    // open drain, wired-and lives outside
    i2c_byte_phy u_phy (
        .CLK    (CLK),
        .RESET  (RESET),
        .sda_in (sda_in),
        .scl    (scl),
        .sda_oe (sda_oe),
        .phy    (phy_bus)
    );

endmodule

`default_nettype wire

// File: tb/eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defs.svh"

module eeprom_model (
    input  wire  scl,
    input  wire  sda,      // resolved bus level
    output logic sda_pull  // 1 pulls sda low
);

    logic [7:0] mem [0:1023];
    logic [7:0] shreg;
    logic [9:0] ptr;
    logic [1:0] blk;
    logic       prev_scl;
    logic       prev_sda;
    logic       active;
    logic       skip_fall; // scl fall that ends a start condition
    logic       rnw;
    logic       go_read;
    logic       mack;
    int         bitcnt;
    int         bytecnt;

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 8'h00;
        end
        sda_pull  = 1'b0;
        active    = 1'b0;
        skip_fall = 1'b0;
        rnw       = 1'b0;
        go_read   = 1'b0;
        mack      = 1'b0;
        bitcnt    = 0;
        bytecnt   = 0;
        ptr       = '0;
        blk       = '0;
        shreg     = '0;
        prev_scl  = scl;
        prev_sda  = sda;
        forever begin
            @(scl or sda);
            if (scl === prev_scl) begin
                if (scl === 1'b1 && prev_sda === 1'b1 && sda === 1'b0) begin
                    active    = 1'b1; // start or repeated start
                    skip_fall = 1'b1;
                    rnw       = 1'b0;
                    go_read   = 1'b0;
                    bitcnt    = 0;
                    bytecnt   = 0;
                    sda_pull  = 1'b0;
                end else if (scl === 1'b1 && prev_sda === 1'b0 && sda === 1'b1) begin
                    active   = 1'b0; // stop
                    sda_pull = 1'b0;
                end
            end else if (scl === 1'b1 && prev_scl === 1'b0) begin
                if (active && bitcnt < 8 && !rnw) begin
                    shreg = {shreg[6:0], sda};
                end else if (active && bitcnt == 8 && rnw) begin
                    mack = !sda;
                end
            end else if (scl === 1'b0 && prev_scl === 1'b1) begin
                if (skip_fall) begin
                    skip_fall = 1'b0;
                end else if (active) begin
                    if (bitcnt < 8) begin
                        bitcnt++;
                        if (bitcnt == 8) begin
                            if (rnw) begin
                                sda_pull = 1'b0; // master owns the ack bit
                            end else begin
                                sda_pull = 1'b1;
                                if (bytecnt == 0) begin
                                    if (shreg[7:4] != `EE_DEV_TYPE || shreg[3]) begin
                                        sda_pull = 1'b0; // not us, stay quiet
                                        active   = 1'b0;
                                    end else begin
                                        blk     = shreg[2:1];
                                        go_read = shreg[0];
                                    end
                                end else if (bytecnt == 1) begin
                                    ptr = {blk, shreg};
                                end else begin
                                    mem[ptr] = shreg;
                                end
                                bytecnt++;
                            end
                        end else if (rnw) begin
                            sda_pull = !shreg[7-bitcnt];
                        end
                    end else begin
                        bitcnt   = 0;
                        sda_pull = 1'b0;
                        if (go_read) begin
                            go_read  = 1'b0;
                            rnw      = 1'b1;
                            shreg    = mem[ptr];
                            sda_pull = !shreg[7];
                        end else if (rnw) begin
                            if (mack) begin
                                ptr      = ptr + 10'd1;
                                shreg    = mem[ptr];
                                sda_pull = !shreg[7];
                            end else begin
                                active = 1'b0; // nack ends the read
                            end
                        end
                    end
                end
            end
            prev_scl = scl;
            prev_sda = sda;
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_eeprom_subsys.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defs.svh"

module tb_eeprom_subsys;

    logic                  CLK;
    logic                  RESET;
    logic                  a_wr;
    logic                  a_rd;
    logic [`EE_ADDR_W-1:0] a_addr;
    logic [`EE_DATA_W-1:0] a_wdata;
    logic                  b_wr;
    logic                  b_rd;
    logic [`EE_ADDR_W-1:0] b_addr;
    logic [`EE_DATA_W-1:0] b_wdata;
    logic                  a_ack;
    logic [`EE_DATA_W-1:0] a_rdata;
    logic                  a_err;
    logic                  b_ack;
    logic [`EE_DATA_W-1:0] b_rdata;
    logic                  b_err;
    logic                  scl;
    logic                  sda_oe;
    logic                  model_pull;
    wire                   sda;

    logic [7:0] shadow [0:1023];
    int         seed;

    assign sda = !(sda_oe || model_pull); // wired-and of both open drains

    eeprom_subsys dut (
        .CLK(CLK), .RESET(RESET),
        .a_wr(a_wr), .a_rd(a_rd), .a_addr(a_addr), .a_wdata(a_wdata),
        .b_wr(b_wr), .b_rd(b_rd), .b_addr(b_addr), .b_wdata(b_wdata),
        .sda_in(sda),
        .a_ack(a_ack), .a_rdata(a_rdata), .a_err(a_err),
        .b_ack(b_ack), .b_rdata(b_rdata), .b_err(b_err),
        .scl(scl), .sda_oe(sda_oe)
    );

    eeprom_model u_model (.scl(scl), .sda(sda), .sda_pull(model_pull));

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic check_value(input int got, input int exp, input string msg);
        if (got != exp) begin
            $display("** Error at time %0t: %s (got %0h, expected %0h)", $time, msg, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // op 0 none, 1 write, 2 read
    task automatic drive_req(input int port, input int op, input logic [10:0] addr,
                             input logic [7:0] wdata);
        if (port == 0) begin
            a_wr    = (op == 1);
            a_rd    = (op == 2);
            a_addr  = addr;
            a_wdata = wdata;
        end else begin
            b_wr    = (op == 1);
            b_rd    = (op == 2);
            b_addr  = addr;
            b_wdata = wdata;
        end
    endtask

    task automatic run_port(input int port, input int op, input logic [10:0] addr,
                            input logic [7:0] wdata, output logic [7:0] rdata,
                            output logic err);
        int   n;
        logic ack;
        n     = 0;
        ack   = 1'b0;
        rdata = '0;
        err   = 1'b0;
        if (op != 0) begin
            drive_req(port, op, addr, wdata);
            while (!ack) begin
                @(posedge CLK);
                #1;
                n++;
                if (n > 2000) begin
                    $display("timeout waiting for ack on port %0d", port);
                    $display("Checks failed");
                    $fatal(1);
                end
                ack   = (port == 0) ? a_ack : b_ack;
                rdata = (port == 0) ? a_rdata : b_rdata;
                err   = (port == 0) ? a_err : b_err;
            end
            drive_req(port, 0, '0, '0);
        end
    endtask

    task automatic apply_vector_file();
        int         fd;
        int         n;
        int         v [0:9];
        string      line;
        logic [7:0] ra;
        logic [7:0] rb;
        logic       ea;
        logic       eb;
        fd = $fopen("tb/golden_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/golden_vectors.txt");
            $display("Checks failed");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2], v[3],
                            v[4], v[5], v[6], v[7], v[8], v[9]);
                if (n == 10) begin
                    @(posedge CLK);
                    #1;
                    fork
                        run_port(0, v[0], 11'(v[1]), 8'(v[2]), ra, ea);
                        run_port(1, v[5], 11'(v[6]), 8'(v[7]), rb, eb);
                    join
                    for (int p = 0; p < 2; p++) begin
                        if (v[5*p] != 0) begin
                            check_value(p == 0 ? int'(ra) : int'(rb), v[5*p+3], "golden rdata");
                            check_value(p == 0 ? int'(ea) : int'(eb), v[5*p+4], "golden err");
                            if (v[5*p] == 1 && v[5*p+4] == 0) begin
                                shadow[v[5*p+1] & 1023] = 8'(v[5*p+2]);
                            end
                        end
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        logic [10:0] addr;
        logic [7:0]  data;
        logic [7:0]  rd;
        logic        er;
        int          port;
        seed  = 87008;
        RESET = 1'b1;
        drive_req(0, 0, '0, '0);
        drive_req(1, 0, '0, '0);
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = 8'h00;
        end
        repeat (5) @(posedge CLK);
        #1 RESET = 1'b0;
        check_value(int'(scl), 1, "scl idle level");
        check_value(int'(sda_oe), 0, "sda_oe idle level");
        repeat (20) begin
            @(posedge CLK);
            #1;
            check_value(int'(a_ack | b_ack), 0, "ack without request");
        end
        apply_vector_file();
        for (int i = 0; i < 16; i++) begin
            port = $random(seed) & 1;
            addr = 11'($random(seed) & 1023);
            data = 8'($random(seed));
            @(posedge CLK);
            #1;
            run_port(port, 1, addr, data, rd, er);
            check_value(int'(er), 0, "random write err");
            shadow[addr[9:0]] = data;
            port = $random(seed) & 1;
            @(posedge CLK);
            #1;
            run_port(port, 2, addr, 8'h00, rd, er);
            check_value(int'(er), 0, "random read err");
            check_value(int'(rd), int'(shadow[addr[9:0]]), "random read data");
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
hdl/eeprom_pkg.sv
hdl/eeprom_req_if.sv
hdl/i2c_phy_if.sv
hdl/eeprom_arbiter.sv
hdl/eeprom_sequencer.sv
hdl/i2c_byte_phy.sv
hdl/eeprom_subsys.sv
tb/eeprom_model.sv
tb/tb_eeprom_subsys.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -Ihdl
TOP       = tb_eeprom_subsys
FILELIST  = sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: tb/golden_vectors.txt
# a_op a_addr a_wdata a_exp_rdata a_exp_err b_op b_addr b_wdata b_exp_rdata b_exp_err
# hex fields, op 0 none 1 write 2 read
1 005 3c 00 0 0 000 00 00 0
2 005 00 3c 0 0 000 00 00 0
1 010 11 00 0 0 000 00 00 0
0 000 00 00 0 1 110 22 00 0
1 210 33 00 0 0 000 00 00 0
0 000 00 00 0 1 310 44 00 0
2 010 00 11 0 2 110 00 22 0
2 210 00 33 0 2 310 00 44 0
1 020 55 00 0 2 020 00 55 0
1 040 66 00 0 0 000 00 00 0
1 040 77 00 0 2 040 00 66 0
2 040 00 77 0 0 000 00 00 0
2 405 00 00 1 0 000 00 00 0
0 000 00 00 0 1 605 aa 00 1
0 000 00 00 0 2 005 00 3c 0
1 3ff 5a 00 0 1 000 a5 00 0
2 000 00 a5 0 2 3ff 00 5a 0
